// ==== common/sync_macros.svh ====
// defines for serial bit period, bytes per info frame and bits per character

`ifndef SYNC_MACROS_SVH
`define SYNC_MACROS_SVH

`default_nettype none

// default clock cycles per serial bit
`define SYNC_TBIT_PERIOD 10

// one info frame carries the 32 bit second
`define SYNC_FRAME_BYTES 4

// start bit, eight data bits, stop bit
`define SYNC_CHAR_BITS 10

`default_nettype wire

`endif

// ==== common/sync_pkg.sv ====
// package sync_pkg with vector types for the sync link and the frame state enum

`default_nettype none

package sync_pkg;

	// UTC second count from GPS and as announced on the link
	typedef logic [31:0] utc_sec_t;

	// one byte for the serial transmitter
	typedef logic [7:0] tx_byte_t;

	// clock cycles per serial bit
	typedef logic [19:0] bit_period_t;

	// info frame controller states
	typedef enum logic [3:0] {
		st_idle    = 4'h0,
		st_fire_b3 = 4'h1,
		st_wait_b3 = 4'h2,
		st_fire_b2 = 4'h3,
		st_wait_b2 = 4'h4,
		st_fire_b1 = 4'h5,
		st_wait_b1 = 4'h6,
		st_fire_b0 = 4'h7,
		st_wait_b0 = 4'h8,
		st_done    = 4'hf
	} frame_state_t;

endpackage

`default_nettype wire

// ==== info_tx_phy/info_tx_phy.sv ====
// module info_tx_phy: async serial byte transmitter with programmable bit period

`include "sync_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module info_tx_phy (
	input  wire                   clk_sys,
	input  wire                   rst_n,
	input  wire                   fire_tx,
	input  sync_pkg::tx_byte_t    data_tx,
	input  sync_pkg::bit_period_t tbit_period,
	output logic                  tx,
	output logic                  done_tx
);

	import sync_pkg::*;

	localparam int CHAR_BITS = `SYNC_CHAR_BITS;
	localparam int IDX_W     = $clog2(CHAR_BITS);

	logic                 active;
	bit_period_t          cyc_cnt;
	logic [IDX_W-1:0]     bit_idx;
	// remaining data bits with the stop bit on top
	logic [CHAR_BITS-2:0] shreg;
	logic                 bit_end;
	logic                 last_bit;

	assign bit_end  = (cyc_cnt == tbit_period - bit_period_t'(1));
	assign last_bit = (bit_idx == IDX_W'(CHAR_BITS - 1));

	// final cycle of the stop bit
	assign done_tx = active && bit_end && last_bit;

	// --------------------
	// bit timing
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			cyc_cnt <= '0;
			bit_idx <= '0;
		end else if (!active) begin
			if (fire_tx) begin
				active  <= 1'b1;
				cyc_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (bit_end) begin
			cyc_cnt <= '0;
			if (last_bit) begin
				active <= 1'b0;
			end else begin
				bit_idx <= bit_idx + IDX_W'(1);
			end
		end else begin
			cyc_cnt <= cyc_cnt + bit_period_t'(1);
		end
	end

	// --------------------
	// line driver
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tx <= 1'b1;
		end else if (!active) begin
			// start bit right after the strobe
			tx <= fire_tx ? 1'b0 : 1'b1;
		end else if (bit_end) begin
			tx <= last_bit ? 1'b1 : shreg[0];
		end
	end

	// data lsb first, then stop
	always_ff @(posedge clk_sys) begin
		if (!active && fire_tx) begin
			shreg <= {1'b1, data_tx};
		end else if (active && bit_end) begin
			shreg <= {1'b1, shreg[CHAR_BITS-2:1]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/utc_second_tracker.sv ====
// module utc_second_tracker: GPS second latch, continuity check and announced second

`timescale 1ns/100ps
`default_nettype none

module utc_second_tracker (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire                fire_sync,
	input  wire                fire_info,
	input  sync_pkg::utc_sec_t utc_sec_gps,
	output sync_pkg::utc_sec_t utc_sec,
	output logic               err
);

	import sync_pkg::*;

	// last GPS count seen on one strobe kind
	typedef struct packed {
		logic     seen;
		utc_sec_t sec;
	} gps_mark_t;

	gps_mark_t mark_sync;
	gps_mark_t mark_info;
	logic      err_sync;
	logic      err_info;

	// count must step by exactly one since the last strobe of this kind
	function automatic logic step_bad(input gps_mark_t mark, input utc_sec_t gps);
		step_bad = mark.seen && (gps != mark.sec + utc_sec_t'(1));
	endfunction

	assign err_sync = fire_sync && step_bad(mark_sync, utc_sec_gps);
	assign err_info = fire_info && step_bad(mark_info, utc_sec_gps);

	// --------------------
	// last seen counts
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mark_sync <= '0;
			mark_info <= '0;
		end else begin
			if (fire_sync) begin
				mark_sync <= '{seen: 1'b1, sec: utc_sec_gps};
			end
			if (fire_info) begin
				mark_info <= '{seen: 1'b1, sec: utc_sec_gps};
			end
		end
	end

	// --------------------
	// error pulse and announced second
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			err     <= 1'b0;
			utc_sec <= '0;
		end else begin
			err <= err_sync | err_info;
			// link announces the second that starts at the next strobe
			if (fire_sync) begin
				utc_sec <= utc_sec_gps + utc_sec_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/info_frame_ctrl.sv ====
// module info_frame_ctrl: FSM that snapshots the second and sends it as four bytes

`include "sync_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module info_frame_ctrl (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire                fire_info,
	input  sync_pkg::utc_sec_t utc_sec,
	input  wire                done_tx,
	output logic               fire_tx,
	output sync_pkg::tx_byte_t data_tx,
	output logic               busy
);

	import sync_pkg::*;

	localparam int FRAME_BYTES = `SYNC_FRAME_BYTES;
	localparam int SEL_W       = $clog2(FRAME_BYTES);

	frame_state_t     state;
	utc_sec_t         snap;
	logic             fire_state;
	logic [SEL_W-1:0] byte_sel;

	// byte of the snapshot for each fire state, msb first
	always_comb begin
		fire_state = 1'b1;
		byte_sel   = '0;
		case (state)
			st_fire_b3: byte_sel = SEL_W'(3);
			st_fire_b2: byte_sel = SEL_W'(2);
			st_fire_b1: byte_sel = SEL_W'(1);
			st_fire_b0: byte_sel = SEL_W'(0);
			default:    fire_state = 1'b0;
		endcase
	end

	// --------------------
	// frame state machine
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:    state <= fire_info ? st_fire_b3 : st_idle;
				st_fire_b3: state <= st_wait_b3;
				st_wait_b3: state <= done_tx ? st_fire_b2 : st_wait_b3;
				st_fire_b2: state <= st_wait_b2;
				st_wait_b2: state <= done_tx ? st_fire_b1 : st_wait_b2;
				st_fire_b1: state <= st_wait_b1;
				st_wait_b1: state <= done_tx ? st_fire_b0 : st_wait_b1;
				st_fire_b0: state <= st_wait_b0;
				st_wait_b0: state <= done_tx ? st_done : st_wait_b0;
				st_done:    state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	// frame content is frozen here, later sync strobes go to the next frame
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && fire_info) begin
			snap <= utc_sec;
		end
	end

	// --------------------
	// byte strobe to the transmitter
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fire_tx <= 1'b0;
			data_tx <= '0;
		end else begin
			fire_tx <= fire_state;
			if (fire_state) begin
				data_tx <= snap[8*byte_sel +: 8];
			end else if (state == st_done) begin
				data_tx <= '0;
			end
		end
	end

	assign busy = (state != st_idle);

endmodule

`default_nettype wire

// ==== hw/sync_master_info.sv ====
// module sync_master_info: top level of the sync master info link

`include "sync_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module sync_master_info #(
	parameter sync_pkg::bit_period_t TBIT_PERIOD = `SYNC_TBIT_PERIOD
) (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire                fire_sync,
	input  wire                fire_info,
	input  sync_pkg::utc_sec_t utc_sec_gps,
	output wire                tx_info,
	output wire                err,
	output wire                busy
);

	import sync_pkg::*;

	utc_sec_t utc_sec;
	logic     fire_tx;
	tx_byte_t data_tx;
	logic     done_tx;

	// --------------------
	// second tracking
	utc_second_tracker u_tracker (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fire_sync   (fire_sync),
		.fire_info   (fire_info),
		.utc_sec_gps (utc_sec_gps),
		.utc_sec     (utc_sec),
		.err         (err)
	);

	// frame sequencing
	info_frame_ctrl u_ctrl (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire_info (fire_info),
		.utc_sec   (utc_sec),
		.done_tx   (done_tx),
		.fire_tx   (fire_tx),
		.data_tx   (data_tx),
		.busy      (busy)
	);

	// serial line
	info_tx_phy u_phy (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fire_tx     (fire_tx),
		.data_tx     (data_tx),
		.tbit_period (TBIT_PERIOD),
		.tx          (tx_info),
		.done_tx     (done_tx)
	);

endmodule

`default_nettype wire

// ==== tb/tb_sync_master_info.sv ====
// module tb_sync_master_info: testbench with stimulus file, serial decoder and watchdog

`include "sync_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_sync_master_info;

	import sync_pkg::*;

	localparam int TBIT        = `SYNC_TBIT_PERIOD;
	localparam int CLK_NS      = 20;
	localparam int BIT_NS      = TBIT * CLK_NS;
	localparam int FRAME_BYTES = `SYNC_FRAME_BYTES;
	localparam int CHAR_BITS   = `SYNC_CHAR_BITS;
	localparam int MAX_TESTS   = 64;

	// one stimulus line
	typedef struct packed {
		logic [7:0] cmd;
		utc_sec_t   gps;
		logic       err;
		utc_sec_t   frame;
	} stim_t;

	// frame expected on the serial line
	typedef struct packed {
		int       tidx;
		utc_sec_t frame;
	} pend_t;

	logic     clk_sys;
	logic     rst_n;
	logic     fire_sync;
	logic     fire_info;
	utc_sec_t utc_sec_gps;
	logic     tx_info;
	logic     err;
	logic     busy;

	stim_t stim_a [0:MAX_TESTS-1];
	bit    bad_a [0:MAX_TESTS-1];
	pend_t pend_q [$];
	int    n_tests;
	int    pass_cnt;
	int    fail_cnt;
	bit    loaded;
	bit    dec_active;
	bit    stim_ok;

	sync_master_info uut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fire_sync   (fire_sync),
		.fire_info   (fire_info),
		.utc_sec_gps (utc_sec_gps),
		.tx_info     (tx_info),
		.err         (err),
		.busy        (busy)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	// --------------------
	// helpers
	task automatic load_stim(output bit ok);
		int         fd;
		int         r;
		string      line;
		logic [7:0] c;
		utc_sec_t   g;
		int         e;
		utc_sec_t   f;
		n_tests = 0;
		fd = $fopen("tb/sync_stim.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && n_tests < MAX_TESTS - 1) begin
				r = $fgets(line, fd);
				// skip blank and comment lines
				if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
					r = $sscanf(line, "%c %h %d %h", c, g, e, f);
					if (r == 4) begin
						n_tests++;
						stim_a[n_tests] = '{cmd: c, gps: g, err: (e != 0), frame: f};
					end
				end
			end
			$fclose(fd);
		end
		ok = (n_tests > 0);
	endtask

	task automatic report_test(input int t);
		if (bad_a[t]) begin
			fail_cnt++;
			$display("test %0d %c %08h: failed", t, stim_a[t].cmd, stim_a[t].gps);
		end else begin
			pass_cnt++;
			$display("test %0d %c %08h: passed", t, stim_a[t].cmd, stim_a[t].gps);
		end
	endtask

	// err pulse one cycle after the strobe, gone the cycle after
	task automatic check_err(input int t);
		if (err !== stim_a[t].err) begin
			$display("[FAIL] test %0d: err got %h expected %h", t, err, stim_a[t].err);
			bad_a[t] = 1'b1;
		end
		@(posedge clk_sys);
		#2;
		if (err !== 1'b0) begin
			$display("[FAIL] test %0d: err after pulse got %h expected 0", t, err);
			bad_a[t] = 1'b1;
		end
	endtask

	task automatic fire_strobe(input int t, input bit is_sync);
		@(posedge clk_sys);
		#2;
		utc_sec_gps = stim_a[t].gps;
		fire_sync   = is_sync;
		fire_info   = !is_sync;
		@(posedge clk_sys);
		#2;
		fire_sync = 1'b0;
		fire_info = 1'b0;
		check_err(t);
	endtask

	// frame over and line decoded
	task automatic wait_idle;
		pend_t p;
		while (busy !== 1'b0) begin
			@(posedge clk_sys);
			#2;
		end
		repeat (2) begin
			@(posedge clk_sys);
			#2;
		end
		if (dec_active) begin
			$display("frame on tx_info stopped before %0d bytes", FRAME_BYTES);
			fail_cnt++;
		end
		while (pend_q.size() > 0) begin
			p = pend_q.pop_front();
			$display("test %0d: no frame seen on tx_info", p.tidx);
			bad_a[p.tidx] = 1'b1;
			report_test(p.tidx);
		end
	endtask

	// --------------------
	// serial decoder, samples mid bit and half a clock off the edges
	initial begin : decoder
		pend_t      p;
		utc_sec_t   got;
		logic [7:0] b;
		dec_active = 1'b0;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge tx_info);
			dec_active = 1'b1;
			p = '{tidx: -1, frame: '0};
			if (pend_q.size() == 0) begin
				$display("unexpected frame on tx_info without an info strobe");
				fail_cnt++;
			end else begin
				p = pend_q.pop_front();
			end
			got = '0;
			for (int k = 0; k < FRAME_BYTES; k++) begin
				if (k > 0) begin
					@(negedge tx_info);
				end
				#(BIT_NS / 2 + CLK_NS / 2);
				if (busy !== 1'b1 && p.tidx >= 0) begin
					$display("[FAIL] test %0d: busy got %h expected 1", p.tidx, busy);
					bad_a[p.tidx] = 1'b1;
				end
				for (int i = 0; i < 8; i++) begin
					#(BIT_NS);
					b = {tx_info, b[7:1]};
				end
				#(BIT_NS);
				if (tx_info !== 1'b1 && p.tidx >= 0) begin
					$display("test %0d: stop bit of byte %0d is not high", p.tidx, k);
					bad_a[p.tidx] = 1'b1;
				end
				got = {got[23:0], b};
			end
			dec_active = 1'b0;
			if (p.tidx >= 0) begin
				if (got !== p.frame) begin
					$display("[FAIL] test %0d: tx_info frame got %08h expected %08h",
						p.tidx, got, p.frame);
					bad_a[p.tidx] = 1'b1;
				end
				report_test(p.tidx);
			end
		end
	end

	// worst case is a full frame per test, with margin
	initial begin : watchdog
		longint wd_ns;
		wait (loaded);
		wd_ns = longint'(n_tests + 1) * FRAME_BYTES * CHAR_BITS * TBIT * CLK_NS * 3;
		#(wd_ns);
		$display("watchdog expired after %0d ns with tests still running", wd_ns);
		$display("Testbench failed");
		$finish;
	end

	// --------------------
	// main sequence
	initial begin
		rst_n       = 1'b0;
		fire_sync   = 1'b0;
		fire_info   = 1'b0;
		utc_sec_gps = '0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		loaded      = 1'b0;
		load_stim(stim_ok);
		if (!stim_ok) begin
			$display("stimulus file tb/sync_stim.txt is missing or holds no tests");
			$display("Testbench failed");
			$finish;
		end else begin
			loaded = 1'b1;
			stim_a[0] = '{cmd: "R", gps: '0, err: 1'b0, frame: '0};
			repeat (4) @(posedge clk_sys);
			#2;
			rst_n = 1'b1;
			@(posedge clk_sys);
			#2;
			if (tx_info !== 1'b1 || err !== 1'b0 || busy !== 1'b0) begin
				$display("[FAIL] test 0: tx_info/err/busy got %h/%h/%h expected 1/0/0",
					tx_info, err, busy);
				bad_a[0] = 1'b1;
			end
			report_test(0);
			for (int t = 1; t <= n_tests; t++) begin
				case (stim_a[t].cmd)
					"S": begin
						fire_strobe(t, 1'b1);
						report_test(t);
					end
					"I": begin
						wait_idle();
						pend_q.push_back('{tidx: t, frame: stim_a[t].frame});
						fire_strobe(t, 1'b0);
						if (busy !== 1'b1) begin
							$display("[FAIL] test %0d: busy got %h expected 1", t, busy);
							bad_a[t] = 1'b1;
						end
					end
					"B": begin
						if (busy !== 1'b1) begin
							$display("[FAIL] test %0d: busy got %h expected 1", t, busy);
							bad_a[t] = 1'b1;
						end
						fire_strobe(t, 1'b0);
						report_test(t);
					end
					default: begin
						$display("test %0d: unknown command in stimulus file", t);
						fail_cnt++;
					end
				endcase
			end
			wait_idle();
			$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/sync_pkg.sv
info_tx_phy/info_tx_phy.sv
hw/utc_second_tracker.sv
hw/info_frame_ctrl.sv
hw/sync_master_info.sv
tb/tb_sync_master_info.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sync master info testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_sync_master_info

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
	--top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build error"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0

// ==== tb/sync_stim.txt ====
# cmd: S sync strobe, I info strobe, B info strobe while busy
# cmd gps_count_hex expected_err expected_frame_hex (frame only used on I lines)
I 00000050 0 00000000
S 12345677 0 00000000
I 00000051 0 12345678
S 12345678 0 00000000
S 12345679 0 00000000
S 1234567b 1 00000000
S 1234567b 1 00000000
I 00000052 0 1234567c
B 00000053 0 00000000
S 1234567c 0 00000000
I 00000055 1 1234567d
B 00000055 1 00000000
S ffffffff 1 00000000
I 00000056 0 00000000
S 00000000 0 00000000
I 00000057 0 00000001
S a5c3e17e 1 00000000
I 00000058 0 a5c3e17f
